/* src.f */
dmem_pkg.sv
dmem_req_queue.sv
dmem_arbiter.sv
dmem_lane_align.sv
dmem_bank.sv
dmem_top.sv
dmem_assert.sv
tb_dmem.sv

/* tb_dmem.sv */
`timescale 1ns/1ns

module tb_dmem import dmem_pkg::*; ();

    localparam int QUEUE_DEPTH = 4;
    localparam int REGION      = 16;  // words per port region
    localparam int NUM_RAND    = 200;
    localparam int TOTAL_REQS  = 2 * (REGION + NUM_RAND) + 6 + REGION;

    logic        clk;
    logic        arst_n;
    logic [1:0]  req_valid;
    dmem_req_t   req [2];
    logic [1:0]  credit;
    logic        rsp_valid;
    dmem_rsp_t   rsp;

    integer      seed;
    int          credits [2];
    int          sent [2];
    int          pulses [2];
    int          streak [2];
    int          data_errs;
    int          credit_errs;
    int          order_errs;
    logic [31:0] model_mem [1024];
    dmem_req_t   exp_q [2][$];

    dmem_top u_dmem_top (
        .clk(clk), .arst_n(arst_n),
        .req_valid0(req_valid[0]), .req0(req[0]),
        .req_valid1(req_valid[1]), .req1(req[1]),
        .credit0(credit[0]), .credit1(credit[1]),
        .rsp_valid(rsp_valid), .rsp(rsp)
    );

    always #4 clk = ~clk;

    function automatic dmem_req_t make_req(input logic we, input dmem_op_e op,
                                           input int addr, input logic [31:0] wdata);
        dmem_req_t r;
        r.we    = we;
        r.op    = op;
        r.addr  = 12'(addr);
        r.wdata = wdata;
        return r;
    endfunction

    function automatic dmem_req_t random_req(input int base);
        logic [31:0] rnd;
        rnd = $random(seed);
        return make_req(rnd[0], dmem_op_e'(rnd[7:4] % 5),
                        (base + rnd[11:8]) * 4 + rnd[13:12], $random(seed));
    endfunction

    // **************************************************
    // reference model, applied in response order
    // **************************************************

    task automatic model_apply(input dmem_req_t r, output logic [31:0] rdata);
        logic [31:0] old_w;
        int          bsh;
        int          hsh;
        old_w = model_mem[r.addr[11:2]];
        bsh   = r.addr[1:0] * 8;
        hsh   = r.addr[1] * 16;
        rdata = '0;  // stores answer with zero
        if (r.we) begin
            case (r.op)
                op_uh, op_sh: model_mem[r.addr[11:2]] = (old_w & ~(32'hffff << hsh))
                                                      | ({16'h0, r.wdata[15:0]} << hsh);
                op_ub, op_sb: model_mem[r.addr[11:2]] = (old_w & ~(32'hff << bsh))
                                                      | ({24'h0, r.wdata[7:0]} << bsh);
                default:      model_mem[r.addr[11:2]] = r.wdata;
            endcase
        end else begin
            case (r.op)
                op_uh, op_sh: rdata = (old_w >> hsh) & 32'hffff;
                op_ub, op_sb: rdata = (old_w >> bsh) & 32'hff;
                default:      rdata = old_w;
            endcase
            if (r.op == op_sh && rdata[15]) rdata = rdata | 32'hffff_0000;
            if (r.op == op_sb && rdata[7]) rdata = rdata | 32'hffff_ff00;
        end
    endtask

    // called a little after a rising edge and returns at the same point of a later cycle
    task automatic send(input int p, input dmem_req_t r);
        while (credits[p] == 0) begin
            @(posedge clk);
            #1;
        end
        req_valid[p] = 1'b1;
        req[p]       = r;
        credits[p]--;
        sent[p]++;
        exp_q[p].push_back(r);
        @(posedge clk);
        #1;
        req_valid[p] = 1'b0;
    endtask

    task automatic port_traffic(input int p, input int base);
        for (int i = 0; i < REGION; i++) begin
            send(p, make_req(1'b1, op_wd, (base + i) * 4, $random(seed)));  // known contents first
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            send(p, random_req(base));
        end
    endtask

    // credits come back one cycle before their responses
    task automatic wait_idle();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_rsp();
        dmem_req_t   r;
        logic [31:0] exp_data;
        int          p;
        int          q;
        p = rsp.port;
        q = 1 - p;
        assert (exp_q[p].size() > 0) else begin
            $display("%0t: response for port %0d with no request outstanding", $time, p);
            order_errs++;
        end
        if (exp_q[p].size() > 0) begin
            r = exp_q[p].pop_front();
            model_apply(r, exp_data);
            assert (rsp.is_load == !r.we) else begin
                $display("ERR %0t rsp.is_load got %0b expected %0b", $time, rsp.is_load, !r.we);
                data_errs++;
            end
            assert (rsp.rdata === exp_data) else begin
                $display("ERR %0t rsp.rdata got %h expected %h", $time, rsp.rdata, exp_data);
                data_errs++;
            end
        end
        // a waiting port may see at most two responses of the other one first
        streak[p] = 0;
        streak[q] = (exp_q[q].size() > 0) ? streak[q] + 1 : 0;
        assert (streak[q] <= 2) else begin
            $display("%0t: port %0d was passed over by %0d responses in a row",
                     $time, q, streak[q]);
            order_errs++;
        end
    endtask

    always @(negedge clk) begin
        if (arst_n) begin
            for (int p = 0; p < 2; p++) begin
                if (credit[p]) begin
                    credits[p]++;
                    pulses[p]++;
                end
                assert (credits[p] <= QUEUE_DEPTH) else begin
                    $display("ERR %0t credits[%0d] got %0d expected at most %0d",
                             $time, p, credits[p], QUEUE_DEPTH);
                    credit_errs++;
                end
            end
            if (rsp_valid) check_rsp();
        end
    end

    // **************************************************
    // stimulus and watchdog
    // **************************************************

    initial begin
        repeat (TOTAL_REQS * 4 + 200) @(posedge clk);
        $display("timeout, the DUT stopped returning credits or responses");
        $display("Test failed");
        $finish;
    end

    initial begin
        seed        = 32'h776e;
        clk         = 1'b0;
        arst_n      = 1'b0;
        req_valid   = '0;
        req[0]      = '0;
        req[1]      = '0;
        credits     = '{QUEUE_DEPTH, QUEUE_DEPTH};
        sent        = '{0, 0};
        pulses      = '{0, 0};
        streak      = '{0, 0};
        data_errs   = 0;
        credit_errs = 0;
        order_errs  = 0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
        fork
            port_traffic(0, 0);
            port_traffic(1, 512);
        join
        send(0, make_req(1'b1, op_wd, 12, 32'h1234_5678));
        send(0, make_req(1'b0, op_wd, 12, 0));
        send(0, make_req(1'b1, op_ub, 13, 32'h0000_00ab));  // only lane 1 changes
        send(0, make_req(1'b1, op_sh, 18, 32'h0000_8001));
        send(0, make_req(1'b0, op_wd, 12, 0));
        send(0, make_req(1'b0, op_wd, 16, 0));
        wait_idle();
        for (int i = 0; i < REGION; i++) begin
            send(1, make_req(1'b0, op_wd, i * 4, 0));  // port 1 reads what port 0 left
        end
        wait_idle();
        for (int p = 0; p < 2; p++) begin
            assert (pulses[p] == sent[p]) else begin
                $display("ERR %0t pulses[%0d] got %0d expected %0d", $time, p, pulses[p], sent[p]);
                credit_errs++;
            end
        end
        $display("errors: data %0d, credit %0d, order %0d", data_errs, credit_errs, order_errs);
        if (data_errs + credit_errs + order_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* dmem_assert.sv */
`timescale 1ns/1ns

module dmem_assert import dmem_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input logic                                 clk,
    input logic                                 arst_n,
    input logic [NUM_PORTS-1:0]                 pop,
    input logic                                 grant_valid,
    input logic                                 rsp_valid,
    input logic                                 req_valid0,
    input logic                                 req_valid1,
    input logic [$clog2(QUEUE_DEPTH + 1)-1:0]   count0,
    input logic [$clog2(QUEUE_DEPTH + 1)-1:0]   count1
);

    // **************************************************
    // arbiter, bank and queue properties
    // **************************************************

    a_pop_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(pop))
        else $error("more than one queue popped in the same cycle");

    // every grant turns into exactly one response on the next cycle
    a_rsp_follows_grant: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid == $past(grant_valid))
        else $error("rsp_valid does not follow grant_valid by one cycle");

    a_no_push_full0: assert property (@(posedge clk) disable iff (!arst_n)
        !(req_valid0 && count0 == QUEUE_DEPTH))
        else $error("port 0 request arrived while its queue was full");

    a_no_push_full1: assert property (@(posedge clk) disable iff (!arst_n)
        !(req_valid1 && count1 == QUEUE_DEPTH))
        else $error("port 1 request arrived while its queue was full");

endmodule

bind dmem_top dmem_assert #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_assert (
    .clk(clk), .arst_n(arst_n), .pop(pop),
    .grant_valid(grant_valid), .rsp_valid(rsp_valid),
    .req_valid0(req_valid0), .req_valid1(req_valid1),
    .count0(u_queue0.count), .count1(u_queue1.count)
);

/* dmem_top.sv */
`timescale 1ns/1ns

module dmem_top import dmem_pkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int WORD_AW     = 10
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      req_valid0,
    input  dmem_req_t req0,
    input  logic      req_valid1,
    input  dmem_req_t req1,
    output logic      credit0,
    output logic      credit1,
    output logic      rsp_valid,
    output dmem_rsp_t rsp
);

    logic [NUM_PORTS-1:0] not_empty;
    logic [NUM_PORTS-1:0] pop;
    dmem_req_t            head0;
    dmem_req_t            head1;
    logic                 grant_valid;
    dmem_grant_t          grant;
    dmem_word_u           old_word;
    dmem_word_u           new_word;
    logic [31:0]          load_data;

    // **************************************************
    // per-port request queues
    // **************************************************

    dmem_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue0 (
        .clk(clk), .arst_n(arst_n),
        .req_valid(req_valid0), .req(req0), .pop(pop[0]),
        .not_empty(not_empty[0]), .head(head0), .credit(credit0)
    );

    dmem_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue1 (
        .clk(clk), .arst_n(arst_n),
        .req_valid(req_valid1), .req(req1), .pop(pop[1]),
        .not_empty(not_empty[1]), .head(head1), .credit(credit1)
    );

    // **************************************************
    // arbitration and the shared bank
    // **************************************************

    dmem_arbiter u_arbiter (
        .clk(clk), .arst_n(arst_n),
        .not_empty(not_empty), .head0(head0), .head1(head1),
        .pop(pop), .grant_valid(grant_valid), .grant(grant)
    );

    dmem_lane_align u_align (
        .grant(grant), .old_word(old_word),
        .new_word(new_word), .load_data(load_data)
    );

    dmem_bank #(.WORD_AW(WORD_AW)) u_bank (
        .clk(clk), .arst_n(arst_n),
        .grant_valid(grant_valid), .grant(grant),
        .new_word(new_word), .load_data(load_data),
        .old_word(old_word), .rsp_valid(rsp_valid), .rsp(rsp)
    );

endmodule

/* dmem_bank.sv */
`timescale 1ns/1ns

module dmem_bank import dmem_pkg::*; #(
    parameter int WORD_AW = 10
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        grant_valid,
    input  dmem_grant_t grant,
    input  dmem_word_u  new_word,
    input  logic [31:0] load_data,
    output dmem_word_u  old_word,
    output logic        rsp_valid,
    output dmem_rsp_t   rsp
);

    logic [WORD_AW-1:0] word_addr;
    logic               wr_en;
    wire  [3:0][7:0]    rd_bytes;

    assign word_addr = grant.req.addr[WORD_AW+1:2];  // drop the byte offset
    assign wr_en     = grant_valid && grant.req.we;

    // **************************************************
    // byte-lane storage
    // **************************************************

    for (genvar lane = 0; lane < 4; lane++) begin : g_lane
        logic [7:0] mem [2**WORD_AW];

        assign rd_bytes[lane] = mem[word_addr];  // asynchronous read

        // every lane is written because the aligner already merged the old bytes in
        always_ff @(posedge clk) begin
            if (wr_en) begin
                mem[word_addr] <= new_word.b[lane];
            end
        end
    end

    assign old_word.b = rd_bytes;

    // **************************************************
    // response register
    // **************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= grant_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid) begin
            rsp.port    <= grant.port;
            rsp.is_load <= ~grant.req.we;
            rsp.rdata   <= grant.req.we ? 32'h0 : load_data;
        end
    end

endmodule

/* dmem_lane_align.sv */
`timescale 1ns/1ns

module dmem_lane_align import dmem_pkg::*; (
    input  dmem_grant_t grant,
    input  dmem_word_u  old_word,
    output dmem_word_u  new_word,
    output logic [31:0] load_data
);

    logic [1:0]  byte_sel;
    logic        half_sel;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    logic [31:0] wdata;

    assign byte_sel = grant.req.addr[1:0];
    assign half_sel = grant.req.addr[1];
    assign wdata    = grant.req.wdata;

    // lanes picked through the two union views
    assign lane_byte = old_word.b[byte_sel];
    assign lane_half = old_word.h[half_sel];

    // **************************************************
    // store merge
    // **************************************************

    always_comb begin
        new_word = old_word;  // untouched lanes keep their old bytes
        case (grant.req.op)
            op_wd: begin
                new_word = wdata;  // low address bits are ignored for words
            end
            op_uh, op_sh: begin
                new_word.h[half_sel] = wdata[15:0];
            end
            op_ub, op_sb: begin
                new_word.b[byte_sel] = wdata[7:0];
            end
            default: begin
                new_word = old_word;
            end
        endcase
    end

    // **************************************************
    // load extraction
    // **************************************************

    always_comb begin
        case (grant.req.op)
            op_wd: begin
                load_data = old_word;
            end
            op_uh: begin
                load_data = {16'h0000, lane_half};
            end
            op_sh: begin
                load_data = {{16{lane_half[15]}}, lane_half};
            end
            op_ub: begin
                load_data = {24'h000000, lane_byte};
            end
            op_sb: begin
                load_data = {{24{lane_byte[7]}}, lane_byte};
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

/* dmem_arbiter.sv */
`timescale 1ns/1ns

module dmem_arbiter import dmem_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [NUM_PORTS-1:0] not_empty,
    input  dmem_req_t            head0,
    input  dmem_req_t            head1,
    output logic [NUM_PORTS-1:0] pop,
    output logic                 grant_valid,
    output dmem_grant_t          grant
);

    port_id_t last_winner;
    port_id_t winner;

    // **************************************************
    // round-robin choice
    // **************************************************

    always_comb begin
        if (not_empty[0] && not_empty[1]) begin
            winner = ~last_winner;  // both waiting, so turn goes to the other port
        end else if (not_empty[1]) begin
            winner = 1'b1;
        end else begin
            winner = 1'b0;
        end
    end

    assign grant_valid = |not_empty;

    always_comb begin
        pop = '0;
        if (grant_valid) begin
            pop[winner] = 1'b1;
        end
    end

    // tag the winning request with where it came from
    always_comb begin
        grant.req  = winner ? head1 : head0;
        grant.port = winner;
    end

    // starting at port 1 means the first contended grant goes to port 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_winner <= 1'b1;
        end else if (grant_valid) begin
            last_winner <= winner;
        end
    end

endmodule

/* dmem_req_queue.sv */
`timescale 1ns/1ns

module dmem_req_queue import dmem_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      req_valid,
    input  dmem_req_t req,
    input  logic      pop,
    output logic      not_empty,
    output dmem_req_t head,
    output logic      credit
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    dmem_req_t        entries [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // **************************************************
    // pointer and count update
    // **************************************************

    // the host only sends while it holds a credit, so a push never finds the queue full
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // push and pop together leave it alone
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (req_valid) begin
            entries[wr_ptr] <= req;
        end
    end

    assign not_empty = (count != '0);
    assign head      = entries[rd_ptr];

    // the slot freed by a dequeue goes straight back to the host
    assign credit = pop;

endmodule

/* dmem_pkg.sv */
package dmem_pkg;

    // **************************************************
    // shared constants and operation codes
    // **************************************************

    localparam int NUM_PORTS = 2;

    typedef logic port_id_t;

    typedef enum logic [2:0] {
        op_wd = 3'd0,  // full word
        op_uh = 3'd1,  // unsigned halfword
        op_ub = 3'd2,  // unsigned byte
        op_sh = 3'd3,  // signed halfword
        op_sb = 3'd4   // signed byte
    } dmem_op_e;

    // **************************************************
    // request, grant and response records
    // **************************************************

    typedef struct packed {
        logic        we;     // set for a store
        dmem_op_e    op;
        logic [11:0] addr;   // byte address
        logic [31:0] wdata;
    } dmem_req_t;

    // the port tag is added once the arbiter has picked a winner
    typedef struct packed {
        dmem_req_t req;
        port_id_t  port;
    } dmem_grant_t;

    typedef struct packed {
        port_id_t    port;
        logic        is_load;
        logic [31:0] rdata;  // zero for stores
    } dmem_rsp_t;

    // one memory word, seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } dmem_word_u;

endpackage
